/* design/acmd23_sequencer.sv */
`timescale 1ns/1ps

module acmd23_sequencer (
	input  logic                  S_AXI_ACLK,
	input  logic                  S_AXI_ARESETN,
	input  logic [1:0]            transfer_mode,
	input  logic                  cmd_write_start,
	input  sd_host_pkg::cmd_int_t cmd_int_st,
	input  logic                  cc_int_puls,
	input  sd_host_pkg::axi_data_t response_0,
	input  logic                  int_clear_pulse,
	output logic                  cmd23_active,
	output logic                  seq_cmd_start,
	output logic                  seq_int_rst,
	output logic                  acmd_error
);
	import sd_host_pkg::*;

	acmd23_state_t state;
	logic          auto_mode;

	assign auto_mode = (transfer_mode == auto_cmd23_mode);

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			state         <= wait_enable;
			cmd23_active  <= 1'b0;
			seq_cmd_start <= 1'b0;
			seq_int_rst   <= 1'b0;
			acmd_error    <= 1'b0;
		end else begin
			seq_cmd_start <= 1'b0;
			seq_int_rst   <= 1'b0;
			case (state)
				wait_enable: begin
					// Auto mode swaps in CMD23 before the host starts
					cmd23_active <= auto_mode;
					if (auto_mode && cmd_write_start) begin
						state <= wait_cmd23_done;
					end
				end
				wait_cmd23_done: begin
					if (cc_int_puls) begin
						if (response_0[15:0] == cmd23_ok_status) begin
							// Card took the count, send the real command
							cmd23_active  <= 1'b0;
							seq_cmd_start <= 1'b1;
							state         <= wait_cmd_done;
						end else begin
							acmd_error <= 1'b1;
							state      <= wait_enable;
						end
					end else if (|cmd_int_st) begin
						// Engine status of CMD23 is not for the host
						seq_int_rst <= 1'b1;
					end
				end
				wait_cmd_done: begin
					if (cc_int_puls) begin
						state <= wait_enable;
					end
				end
				default: state <= wait_enable;
			endcase
			// Host clear removes the auto-command error
			if (int_clear_pulse) begin
				acmd_error <= 1'b0;
			end
		end
	end

endmodule

/* design/axi_lite_slave.sv */
`timescale 1ns/1ps

module axi_lite_slave (
	input  logic                    S_AXI_ACLK,
	input  logic                    S_AXI_ARESETN,
	// Write address and data
	input  sd_host_pkg::axi_addr_t  s_axi_awaddr,
	input  logic                    s_axi_awvalid,
	output logic                    s_axi_awready,
	input  sd_host_pkg::axi_data_t  s_axi_wdata,
	input  sd_host_pkg::axi_strb_t  s_axi_wstrb,
	input  logic                    s_axi_wvalid,
	output logic                    s_axi_wready,
	// Write response
	output logic [1:0]              s_axi_bresp,
	output logic                    s_axi_bvalid,
	input  logic                    s_axi_bready,
	// Read address and data
	input  sd_host_pkg::axi_addr_t  s_axi_araddr,
	input  logic                    s_axi_arvalid,
	output logic                    s_axi_arready,
	output sd_host_pkg::axi_data_t  s_axi_rdata,
	output logic [1:0]              s_axi_rresp,
	output logic                    s_axi_rvalid,
	input  logic                    s_axi_rready,
	// Register file side
	output logic                    reg_wr_en,
	output sd_host_pkg::reg_index_t wr_index,
	output sd_host_pkg::axi_data_t  wr_data,
	output sd_host_pkg::axi_strb_t  wr_strb,
	output sd_host_pkg::reg_index_t rd_index,
	input  sd_host_pkg::axi_data_t  rd_data
);
	import sd_host_pkg::*;

	// Address and data ready share one flop
	logic write_ready;
	logic rd_accept;

	assign s_axi_awready = write_ready;
	assign s_axi_wready  = write_ready;

	// Every access completes with OKAY
	assign s_axi_bresp = resp_okay;
	assign s_axi_rresp = resp_okay;

	// Single beat write with both channels taken in the same cycle
	assign reg_wr_en = write_ready & s_axi_awvalid & s_axi_wvalid;
	assign wr_data   = s_axi_wdata;
	assign wr_strb   = s_axi_wstrb;

	assign rd_accept = s_axi_arready & s_axi_arvalid;

	// Ready pulse once both valids are seen and no response is pending
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			write_ready <= 1'b0;
		end else begin
			write_ready <= !write_ready && s_axi_awvalid && s_axi_wvalid && !s_axi_bvalid;
		end
	end

	// Write word index
	always_ff @(posedge S_AXI_ACLK) begin
		if (!write_ready && s_axi_awvalid && s_axi_wvalid) begin
			wr_index <= s_axi_awaddr[idx_msb:idx_lsb];
		end
	end

	// Response held until the master takes it
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			s_axi_bvalid <= 1'b0;
		end else if (reg_wr_en) begin
			s_axi_bvalid <= 1'b1;
		end else if (s_axi_bready) begin
			s_axi_bvalid <= 1'b0;
		end
	end

	// Read address accepted one cycle after ARVALID
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			s_axi_arready <= 1'b0;
		end else begin
			s_axi_arready <= !s_axi_arready && s_axi_arvalid && !s_axi_rvalid;
		end
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (!s_axi_arready && s_axi_arvalid) begin
			rd_index <= s_axi_araddr[idx_msb:idx_lsb];
		end
	end

	// Read data valid the cycle after the address handshake
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			s_axi_rvalid <= 1'b0;
		end else if (rd_accept) begin
			s_axi_rvalid <= 1'b1;
		end else if (s_axi_rready) begin
			s_axi_rvalid <= 1'b0;
		end
	end

	// Word sampled when the read is accepted
	always_ff @(posedge S_AXI_ACLK) begin
		if (rd_accept) begin
			s_axi_rdata <= rd_data;
		end
	end

endmodule

/* design/host_register_file.sv */
`timescale 1ns/1ps

module host_register_file (
	input  logic                    S_AXI_ACLK,
	input  logic                    S_AXI_ARESETN,
	// Bus side
	input  logic                    reg_wr_en,
	input  sd_host_pkg::reg_index_t wr_index,
	input  sd_host_pkg::axi_data_t  wr_data,
	input  sd_host_pkg::axi_strb_t  wr_strb,
	input  sd_host_pkg::reg_index_t rd_index,
	output sd_host_pkg::axi_data_t  rd_data,
	// Read-only sources
	input  sd_host_pkg::axi_data_t  response_0,
	input  sd_host_pkg::axi_data_t  response_1,
	input  sd_host_pkg::axi_data_t  response_2,
	input  sd_host_pkg::axi_data_t  response_3,
	input  sd_host_pkg::int_word_t  status_word,
	input  logic                    clk_stable,
	input  logic                    cmd23_active,
	// Control outputs
	output sd_host_pkg::axi_data_t  argument_reg,
	output sd_host_pkg::cmd_field_t command_reg,
	output sd_host_pkg::blk_size_t  block_size,
	output sd_host_pkg::blk_count_t block_count,
	output logic [7:0]              clock_divisor,
	output logic [1:0]              transfer_mode,
	output sd_host_pkg::int_word_t  int_status_en,
	output sd_host_pkg::int_word_t  int_signal_en,
	output sd_host_pkg::int_word_t  int_clear_mask,
	output logic                    cmd_write_start,
	output logic                    int_clear_pulse
);
	import sd_host_pkg::*;

	axi_data_t arg2_reg;
	axi_data_t blk_reg;
	axi_data_t arg1_reg;
	axi_data_t cmd_reg;
	axi_data_t clk_reg;
	int_word_t int_en_reg;
	int_word_t sig_en_reg;

	// Replace only the bytes whose strobe is set
	function automatic axi_data_t merge_bytes(axi_data_t old_word, axi_data_t new_word,
		axi_strb_t strb);
		axi_data_t merged;
		merged = old_word;
		for (int i = 0; i < 4; i++) begin
			if (strb[i]) begin
				merged[8*i +: 8] = new_word[8*i +: 8];
			end
		end
		return merged;
	endfunction

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			arg2_reg        <= '0;
			blk_reg         <= '0;
			arg1_reg        <= '0;
			cmd_reg         <= '0;
			clk_reg         <= '0;
			int_en_reg      <= '0;
			sig_en_reg      <= '0;
			cmd_write_start <= 1'b0;
			int_clear_pulse <= 1'b0;
		end else begin
			cmd_write_start <= 1'b0;
			int_clear_pulse <= 1'b0;
			if (reg_wr_en) begin
				case (wr_index)
					idx_arg2: arg2_reg <= merge_bytes(arg2_reg, wr_data, wr_strb);
					idx_blk:  blk_reg  <= merge_bytes(blk_reg, wr_data, wr_strb);
					idx_arg1: arg1_reg <= merge_bytes(arg1_reg, wr_data, wr_strb);
					idx_cmd: begin
						cmd_reg <= merge_bytes(cmd_reg, wr_data, wr_strb);
						// Command byte lanes alone launch the command
						cmd_write_start <= (wr_strb == cmd_start_strb);
					end
					idx_clk: clk_reg <= merge_bytes(clk_reg, wr_data, wr_strb);
					// Clear request to both engines
					idx_int_stat: int_clear_pulse <= 1'b1;
					idx_int_en: begin
						int_en_reg <= int_word_t'(merge_bytes(axi_data_t'(int_en_reg),
							wr_data, wr_strb));
					end
					idx_sig_en: begin
						sig_en_reg <= int_word_t'(merge_bytes(axi_data_t'(sig_en_reg),
							wr_data, wr_strb));
					end
					default: ;
				endcase
			end
		end
	end

	// Write-one-to-clear bits present only during the status write
	always_comb begin
		int_clear_mask = '0;
		if (reg_wr_en && wr_index == idx_int_stat) begin
			int_clear_mask = int_word_t'(merge_bytes('0, wr_data, wr_strb));
		end
	end

	// CMD23 and argument 2 go out first in auto mode
	assign command_reg  = cmd23_active ? cmd23_field
		: cmd_reg[cmd_field_lsb +: $bits(cmd_field_t)];
	assign argument_reg = cmd23_active ? arg2_reg : arg1_reg;

	assign block_size    = blk_reg[$bits(blk_size_t)-1:0];
	assign block_count   = blk_reg[blk_count_lsb +: $bits(blk_count_t)];
	// Engine divides by twice the value
	assign clock_divisor = clk_reg[clk_div_lsb +: clk_div_w] >> 1;
	assign transfer_mode = cmd_reg[mode_lsb +: 2];
	assign int_status_en = int_en_reg;
	assign int_signal_en = sig_en_reg;

	// Read decode
	always_comb begin
		case (rd_index)
			idx_arg2:  rd_data = arg2_reg;
			idx_blk:   rd_data = blk_reg;
			idx_arg1:  rd_data = arg1_reg;
			idx_cmd:   rd_data = cmd_reg;
			idx_resp0: rd_data = response_0;
			idx_resp1: rd_data = response_1;
			idx_resp2: rd_data = response_2;
			idx_resp3: rd_data = response_3;
			idx_clk: begin
				rd_data = clk_reg;
				rd_data[clk_stable_bit] = clk_stable;
			end
			// Only enabled status bits are visible
			idx_int_stat: rd_data = axi_data_t'(status_word & int_en_reg);
			idx_int_en:   rd_data = axi_data_t'(int_en_reg);
			idx_sig_en:   rd_data = axi_data_t'(sig_en_reg);
			idx_caps:     rd_data = caps_value;
			idx_version:  rd_data = version_value;
			default:      rd_data = '0;
		endcase
	end

endmodule

/* design/interrupt_status.sv */
`timescale 1ns/1ps

module interrupt_status (
	input  logic                   S_AXI_ACLK,
	input  logic                   S_AXI_ARESETN,
	input  sd_host_pkg::cmd_int_t  cmd_int_st,
	input  sd_host_pkg::dat_int_t  dat_int_st,
	input  logic                   acmd_error,
	input  logic                   cmd23_active,
	input  sd_host_pkg::int_word_t int_clear_mask,
	output sd_host_pkg::int_word_t status_word
);
	import sd_host_pkg::*;

	int_word_t source_word;
	int_word_t clear_mask_q;
	logic      any_source;

	// Source bits at their status positions
	always_comb begin
		source_word = '0;
		// Completion of CMD23 itself is hidden from the host
		source_word[int_cc] = cmd_int_st[0] & ~cmd23_active;
		source_word[int_tc] = dat_int_st[0];
		source_word[int_cmd_err_lsb +: int_err_w] = cmd_int_st[4:1];
		source_word[int_dat_err_lsb +: int_err_w] = dat_int_st[4:1];
		source_word[int_acmd_err] = acmd_error;
	end

	assign any_source = (|cmd_int_st) | (|dat_int_st);

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			clear_mask_q <= '0;
			status_word  <= '0;
		end else begin
			// Mask kept while an engine still reports, dropped once all are idle
			clear_mask_q <= int_clear_mask | (any_source ? clear_mask_q : '0);
			status_word  <= source_word & ~clear_mask_q;
		end
	end

endmodule

/* design/sd_host_pkg.sv */
package sd_host_pkg;

	// Register bus words
	typedef logic [31:0] axi_addr_t;
	typedef logic [31:0] axi_data_t;
	typedef logic [3:0]  axi_strb_t;

	// Word index, address bits 7:2
	typedef logic [5:0] reg_index_t;

	// Command field of register 0x0C: index, type and response flags
	typedef logic [13:0] cmd_field_t;
	typedef logic [11:0] blk_size_t;
	typedef logic [15:0] blk_count_t;

	// Interrupt status, status enable and signal enable
	typedef logic [28:0] int_word_t;

	// Engine status with bit 0 complete and bits 4:1 errors
	typedef logic [4:0] cmd_int_t;
	typedef logic [4:0] dat_int_t;

	// Automatic CMD23 sequence
	typedef enum logic [1:0] {
		wait_enable,
		wait_cmd23_done,
		wait_cmd_done
	} acmd23_state_t;

	// Register word indices
	localparam reg_index_t idx_arg2     = 6'h00;
	localparam reg_index_t idx_blk      = 6'h01;
	localparam reg_index_t idx_arg1     = 6'h02;
	localparam reg_index_t idx_cmd      = 6'h03;
	localparam reg_index_t idx_resp0    = 6'h04;
	localparam reg_index_t idx_resp1    = 6'h05;
	localparam reg_index_t idx_resp2    = 6'h06;
	localparam reg_index_t idx_resp3    = 6'h07;
	localparam reg_index_t idx_clk      = 6'h0B;
	localparam reg_index_t idx_int_stat = 6'h0C;
	localparam reg_index_t idx_int_en   = 6'h0D;
	localparam reg_index_t idx_sig_en   = 6'h0E;
	localparam reg_index_t idx_caps     = 6'h10;
	localparam reg_index_t idx_version  = 6'h3F;

	// Address bits that pick the word
	localparam int idx_lsb = 2;
	localparam int idx_msb = 7;

	// Field positions inside the registers
	localparam int cmd_field_lsb  = 16;
	localparam int blk_count_lsb  = 16;
	localparam int mode_lsb       = 2;
	localparam int clk_div_lsb    = 8;
	localparam int clk_div_w      = 8;
	localparam int clk_stable_bit = 1;

	// Only the two upper bytes that hold the command field start a command
	localparam axi_strb_t cmd_start_strb = 4'hC;
	localparam logic [1:0] auto_cmd23_mode = 2'd2;
	localparam cmd_field_t cmd23_field = 14'h171A;
	// Card status in R1 after a good CMD23
	localparam logic [15:0] cmd23_ok_status = 16'h0900;

	localparam axi_data_t caps_value    = 32'h012C32B2;
	localparam axi_data_t version_value = 32'h00020000;

	// Interrupt bit positions
	localparam int int_cc          = 0;
	localparam int int_tc          = 1;
	localparam int int_cmd_err_lsb = 16;
	localparam int int_dat_err_lsb = 20;
	localparam int int_acmd_err    = 24;
	localparam int int_err_w       = 4;

	localparam logic [1:0] resp_okay = 2'b00;

endpackage

/* design/sd_host_regs_top.sv */
`timescale 1ns/1ps

module sd_host_regs_top (
	input  logic                    S_AXI_ACLK,
	input  logic                    S_AXI_ARESETN,
	// AXI4-Lite slave
	input  sd_host_pkg::axi_addr_t  s_axi_awaddr,
	input  logic                    s_axi_awvalid,
	output logic                    s_axi_awready,
	input  sd_host_pkg::axi_data_t  s_axi_wdata,
	input  sd_host_pkg::axi_strb_t  s_axi_wstrb,
	input  logic                    s_axi_wvalid,
	output logic                    s_axi_wready,
	output logic [1:0]              s_axi_bresp,
	output logic                    s_axi_bvalid,
	input  logic                    s_axi_bready,
	input  sd_host_pkg::axi_addr_t  s_axi_araddr,
	input  logic                    s_axi_arvalid,
	output logic                    s_axi_arready,
	output sd_host_pkg::axi_data_t  s_axi_rdata,
	output logic [1:0]              s_axi_rresp,
	output logic                    s_axi_rvalid,
	input  logic                    s_axi_rready,
	// Command engine side
	input  sd_host_pkg::axi_data_t  response_0,
	input  sd_host_pkg::axi_data_t  response_1,
	input  sd_host_pkg::axi_data_t  response_2,
	input  sd_host_pkg::axi_data_t  response_3,
	input  sd_host_pkg::cmd_int_t   cmd_int_st,
	input  sd_host_pkg::dat_int_t   dat_int_st,
	input  logic                    cc_int_puls,
	input  logic                    clk_stable,
	output sd_host_pkg::cmd_field_t command_reg,
	output sd_host_pkg::axi_data_t  argument_reg,
	output sd_host_pkg::blk_size_t  block_size,
	output sd_host_pkg::blk_count_t block_count,
	output logic [7:0]              clock_divisor,
	output sd_host_pkg::int_word_t  int_status,
	output sd_host_pkg::int_word_t  int_status_en,
	output sd_host_pkg::int_word_t  int_signal_en,
	output logic                    cmd_start,
	output logic                    cmd_int_rst,
	output logic                    dat_int_rst
);
	import sd_host_pkg::*;

	logic       reg_wr_en;
	reg_index_t wr_index;
	axi_data_t  wr_data;
	axi_strb_t  wr_strb;
	reg_index_t rd_index;
	axi_data_t  rd_data;
	int_word_t  status_word;
	int_word_t  int_clear_mask;
	logic [1:0] transfer_mode;
	logic       cmd_write_start;
	logic       int_clear_pulse;
	logic       cmd23_active;
	logic       seq_cmd_start;
	logic       seq_int_rst;
	logic       acmd_error;

	// Host write and sequencer both launch commands
	assign cmd_start   = cmd_write_start | seq_cmd_start;
	assign cmd_int_rst = int_clear_pulse | seq_int_rst;
	assign dat_int_rst = int_clear_pulse;
	assign int_status  = status_word;

	axi_lite_slave i_axi (
		.S_AXI_ACLK, .S_AXI_ARESETN,
		.s_axi_awaddr, .s_axi_awvalid, .s_axi_awready,
		.s_axi_wdata, .s_axi_wstrb, .s_axi_wvalid, .s_axi_wready,
		.s_axi_bresp, .s_axi_bvalid, .s_axi_bready,
		.s_axi_araddr, .s_axi_arvalid, .s_axi_arready,
		.s_axi_rdata, .s_axi_rresp, .s_axi_rvalid, .s_axi_rready,
		.reg_wr_en, .wr_index, .wr_data, .wr_strb, .rd_index, .rd_data
	);

	host_register_file i_regs (
		.S_AXI_ACLK, .S_AXI_ARESETN,
		.reg_wr_en, .wr_index, .wr_data, .wr_strb, .rd_index, .rd_data,
		.response_0, .response_1, .response_2, .response_3,
		.status_word, .clk_stable, .cmd23_active,
		.argument_reg, .command_reg, .block_size, .block_count, .clock_divisor,
		.transfer_mode, .int_status_en, .int_signal_en, .int_clear_mask,
		.cmd_write_start, .int_clear_pulse
	);

	interrupt_status i_int (
		.S_AXI_ACLK, .S_AXI_ARESETN,
		.cmd_int_st, .dat_int_st, .acmd_error, .cmd23_active,
		.int_clear_mask, .status_word
	);

	acmd23_sequencer i_acmd23 (
		.S_AXI_ACLK, .S_AXI_ARESETN,
		.transfer_mode, .cmd_write_start, .cmd_int_st, .cc_int_puls,
		.response_0, .int_clear_pulse,
		.cmd23_active, .seq_cmd_start, .seq_int_rst, .acmd_error
	);

endmodule

/* run.sh */
#!/bin/sh
# Build and run the register block testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_sd_host_regs -f sources.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_sd_host_regs > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Regression failed" sim.log; then
	exit 1
fi
if ! grep -q "Regression passed" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
exit 0

/* sources.f */
design/sd_host_pkg.sv
design/axi_lite_slave.sv
design/host_register_file.sv
design/interrupt_status.sv
design/acmd23_sequencer.sv
design/sd_host_regs_top.sv
tb/sd_host_regs_properties.sv
tb/tb_sd_host_regs.sv

/* tb/sd_host_regs_properties.sv */
`timescale 1ns/1ps

module sd_host_regs_properties (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	input logic s_axi_awready,
	input logic s_axi_wready,
	input logic s_axi_arready,
	input logic s_axi_bvalid,
	input logic s_axi_bready,
	input logic s_axi_rvalid,
	input logic s_axi_rready,
	input logic cmd_start
);

	// Ready outputs are single-cycle pulses
	assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		s_axi_awready |=> !s_axi_awready) else $error("awready held");
	assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		s_axi_wready |=> !s_axi_wready) else $error("wready held");
	assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		s_axi_arready |=> !s_axi_arready) else $error("arready held");

	// Responses stay until taken
	assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid) else $error("bvalid dropped");
	assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid) else $error("rvalid dropped");

	// No command start out of reset
	assert property (@(posedge S_AXI_ACLK)
		!S_AXI_ARESETN |=> !cmd_start) else $error("cmd_start in reset");

endmodule

bind sd_host_regs_top sd_host_regs_properties i_props (.*);

/* tb/tb_sd_host_regs.sv */
`timescale 1ns/1ps

module tb_sd_host_regs;
	import sd_host_pkg::*;

	localparam int timeout_cycles = 64;

	logic       S_AXI_ACLK;
	logic       S_AXI_ARESETN;
	axi_addr_t  s_axi_awaddr;
	logic       s_axi_awvalid;
	logic       s_axi_awready;
	axi_data_t  s_axi_wdata;
	axi_strb_t  s_axi_wstrb;
	logic       s_axi_wvalid;
	logic       s_axi_wready;
	logic [1:0] s_axi_bresp;
	logic       s_axi_bvalid;
	logic       s_axi_bready;
	axi_addr_t  s_axi_araddr;
	logic       s_axi_arvalid;
	logic       s_axi_arready;
	axi_data_t  s_axi_rdata;
	logic [1:0] s_axi_rresp;
	logic       s_axi_rvalid;
	logic       s_axi_rready;
	axi_data_t  response_0;
	axi_data_t  response_1;
	axi_data_t  response_2;
	axi_data_t  response_3;
	cmd_int_t   cmd_int_st;
	dat_int_t   dat_int_st;
	logic       cc_int_puls;
	logic       clk_stable;
	cmd_field_t command_reg;
	axi_data_t  argument_reg;
	blk_size_t  block_size;
	blk_count_t block_count;
	logic [7:0] clock_divisor;
	int_word_t  int_status;
	int_word_t  int_status_en;
	int_word_t  int_signal_en;
	logic       cmd_start;
	logic       cmd_int_rst;
	logic       dat_int_rst;

	// Reference copies of the writable registers
	axi_data_t m_arg2;
	axi_data_t m_blk;
	axi_data_t m_arg1;
	axi_data_t m_cmd;
	axi_data_t m_clk;
	int_word_t m_int_en;
	int_word_t m_sig_en;

	integer seed;
	int     errors;
	int     timeouts;
	int     start_cnt;
	int     crst_cnt;
	int     drst_cnt;

	sd_host_regs_top i_dut (.*);

	initial begin
		S_AXI_ACLK = 1'b0;
		forever #50 S_AXI_ACLK = ~S_AXI_ACLK;
	end

	// Pulse counters sampled before the edge updates them
	always @(posedge S_AXI_ACLK) begin
		if (S_AXI_ARESETN) begin
			if (cmd_start) start_cnt++;
			if (cmd_int_rst) crst_cnt++;
			if (dat_int_rst) drst_cnt++;
		end
	end

	task automatic check(string name, logic [31:0] got, logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic report_timeout(string what);
		$display("Timeout at %0t: no %s within %0d cycles", $time, what, timeout_cycles);
		timeouts++;
	endtask

	// Byte lanes with strobe set take the new data
	function automatic axi_data_t apply_strobes(axi_data_t old_word, axi_data_t new_word,
		axi_strb_t strb);
		axi_data_t lane_mask;
		lane_mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
		return (old_word & ~lane_mask) | (new_word & lane_mask);
	endfunction

	task automatic update_model(axi_addr_t addr, axi_data_t data, axi_strb_t strb);
		axi_data_t tmp;
		case (addr[7:2])
			6'h00: m_arg2 = apply_strobes(m_arg2, data, strb);
			6'h01: m_blk = apply_strobes(m_blk, data, strb);
			6'h02: m_arg1 = apply_strobes(m_arg1, data, strb);
			6'h03: m_cmd = apply_strobes(m_cmd, data, strb);
			6'h0B: m_clk = apply_strobes(m_clk, data, strb);
			6'h0D: begin
				tmp = apply_strobes({3'b0, m_int_en}, data, strb);
				m_int_en = tmp[28:0];
			end
			6'h0E: begin
				tmp = apply_strobes({3'b0, m_sig_en}, data, strb);
				m_sig_en = tmp[28:0];
			end
			default: ;
		endcase
	endtask

	task automatic bus_write(axi_addr_t addr, axi_data_t data, axi_strb_t strb);
		int cnt;
		s_axi_awaddr  = addr;
		s_axi_wdata   = data;
		s_axi_wstrb   = strb;
		s_axi_awvalid = 1'b1;
		s_axi_wvalid  = 1'b1;
		@(negedge S_AXI_ACLK);
		cnt = 1;
		while (!s_axi_awready && cnt < timeout_cycles) begin
			@(negedge S_AXI_ACLK);
			cnt++;
		end
		if (!s_axi_awready) report_timeout("write address ready");
		check("s_axi_wready", 32'(s_axi_wready), 32'd1);
		// Handshake completes on the next edge
		@(negedge S_AXI_ACLK);
		s_axi_awvalid = 1'b0;
		s_axi_wvalid  = 1'b0;
		update_model(addr, data, strb);
		cnt = 0;
		while (!s_axi_bvalid && cnt < timeout_cycles) begin
			@(negedge S_AXI_ACLK);
			cnt++;
		end
		if (!s_axi_bvalid) report_timeout("write response");
		check("s_axi_bresp", 32'(s_axi_bresp), 32'(resp_okay));
		@(negedge S_AXI_ACLK);
	endtask

	task automatic bus_read(axi_addr_t addr, output axi_data_t data);
		int cnt;
		s_axi_araddr  = addr;
		s_axi_arvalid = 1'b1;
		@(negedge S_AXI_ACLK);
		cnt = 1;
		while (!s_axi_arready && cnt < timeout_cycles) begin
			@(negedge S_AXI_ACLK);
			cnt++;
		end
		if (!s_axi_arready) report_timeout("read address ready");
		@(negedge S_AXI_ACLK);
		s_axi_arvalid = 1'b0;
		cnt = 0;
		while (!s_axi_rvalid && cnt < timeout_cycles) begin
			@(negedge S_AXI_ACLK);
			cnt++;
		end
		if (!s_axi_rvalid) report_timeout("read data");
		data = s_axi_rdata;
		check("s_axi_rresp", 32'(s_axi_rresp), 32'(resp_okay));
		@(negedge S_AXI_ACLK);
	endtask

	task automatic read_check(string name, axi_addr_t addr, axi_data_t exp);
		axi_data_t got;
		bus_read(addr, got);
		check(name, got, exp);
	endtask

	// Wait until the start counter reaches a target
	task automatic wait_starts(int target);
		int cnt;
		cnt = 0;
		while (start_cnt < target && cnt < timeout_cycles) begin
			@(negedge S_AXI_ACLK);
			cnt++;
		end
		if (start_cnt < target) report_timeout("cmd_start pulse");
	endtask

	task automatic pulse_cc();
		cc_int_puls = 1'b1;
		@(negedge S_AXI_ACLK);
		cc_int_puls = 1'b0;
	endtask

	task automatic check_outputs();
		check("block_size", 32'(block_size), 32'(m_blk[11:0]));
		check("block_count", 32'(block_count), 32'(m_blk[31:16]));
		check("int_status_en", 32'(int_status_en), 32'(m_int_en));
		check("int_signal_en", 32'(int_signal_en), 32'(m_sig_en));
		check("clock_divisor", 32'(clock_divisor), 32'(m_clk[15:8] >> 1));
	endtask

	// Status bits at their host positions
	function automatic int_word_t source_bits(cmd_int_t c, dat_int_t d);
		int_word_t w;
		w = '0;
		w[0] = c[0];
		w[1] = d[0];
		w[19:16] = c[4:1];
		w[23:20] = d[4:1];
		return w;
	endfunction

	initial begin
		logic [31:0] rnd;
		logic [31:0] wd;
		logic [3:0]  ws;
		logic [5:0]  idx;
		int          base;
		int          crst_base;
		int          drst_base;
		int          i;
		int_word_t   src;
		int_word_t   mask;
		cmd_int_t    c_src;
		dat_int_t    d_src;

		seed = 1;
		errors = 0;
		timeouts = 0;
		start_cnt = 0;
		crst_cnt = 0;
		drst_cnt = 0;
		m_arg2 = '0;
		m_blk = '0;
		m_arg1 = '0;
		m_cmd = '0;
		m_clk = '0;
		m_int_en = '0;
		m_sig_en = '0;
		S_AXI_ARESETN = 1'b0;
		s_axi_awaddr = '0;
		s_axi_awvalid = 1'b0;
		s_axi_wdata = '0;
		s_axi_wstrb = '0;
		s_axi_wvalid = 1'b0;
		s_axi_bready = 1'b1;
		s_axi_araddr = '0;
		s_axi_arvalid = 1'b0;
		s_axi_rready = 1'b1;
		response_0 = '0;
		response_1 = '0;
		response_2 = '0;
		response_3 = '0;
		cmd_int_st = '0;
		dat_int_st = '0;
		cc_int_puls = 1'b0;
		clk_stable = 1'b0;
		repeat (5) @(negedge S_AXI_ACLK);
		S_AXI_ARESETN = 1'b1;
		@(negedge S_AXI_ACLK);
		check_outputs();

		// Random strobed writes with read back
		for (i = 0; i < 40; i++) begin
			rnd = $random(seed);
			case (rnd[2:0] % 3'd7)
				3'd0: idx = idx_arg2;
				3'd1: idx = idx_blk;
				3'd2: idx = idx_arg1;
				3'd3: idx = idx_cmd;
				3'd4: idx = idx_clk;
				3'd5: idx = idx_int_en;
				default: idx = idx_sig_en;
			endcase
			wd = $random(seed);
			ws = rnd[7:4];
			if (idx == idx_cmd) begin
				// Keep out of auto mode and never start here
				wd[3:2] = 2'b00;
				if (ws == cmd_start_strb) ws = 4'h4;
			end
			bus_write({24'h0, idx, 2'b00}, wd, ws);
			case (idx)
				idx_arg2: read_check("arg2", 32'h00, m_arg2);
				idx_blk: read_check("blk", 32'h04, m_blk);
				idx_arg1: read_check("arg1", 32'h08, m_arg1);
				idx_cmd: read_check("cmd", 32'h0C, m_cmd);
				idx_clk: read_check("clk", 32'h2C, {m_clk[31:2], clk_stable, m_clk[0]});
				idx_int_en: read_check("int_en", 32'h34, {3'b0, m_int_en});
				default: read_check("sig_en", 32'h38, {3'b0, m_sig_en});
			endcase
			check_outputs();
			check("command_reg", 32'(command_reg), 32'(m_cmd[29:16]));
			check("argument_reg", argument_reg, m_arg1);
		end

		// Read-only words and unmapped space
		response_0 = $random(seed);
		response_1 = $random(seed);
		response_2 = $random(seed);
		response_3 = $random(seed);
		read_check("response_0", 32'h10, response_0);
		read_check("response_1", 32'h14, response_1);
		read_check("response_2", 32'h18, response_2);
		read_check("response_3", 32'h1C, response_3);
		read_check("caps", 32'h40, 32'h012C32B2);
		read_check("version", 32'hFC, 32'h00020000);
		read_check("unmapped_20", 32'h20, 32'h0);
		read_check("unmapped_80", 32'h80, 32'h0);
		read_check("unmapped_3c", 32'h3C, 32'h0);
		clk_stable = 1'b1;
		read_check("clk_stable_hi", 32'h2C, {m_clk[31:2], 1'b1, m_clk[0]});
		clk_stable = 1'b0;
		read_check("clk_stable_lo", 32'h2C, {m_clk[31:2], 1'b0, m_clk[0]});

		// Command start only with the command byte lanes
		base = start_cnt;
		bus_write(32'h0C, {2'b00, 14'h0123, m_cmd[15:4], 2'b00, m_cmd[1:0]}, 4'hC);
		wait_starts(base + 1);
		repeat (4) @(negedge S_AXI_ACLK);
		check("cmd_start_count", 32'(start_cnt - base), 32'd1);
		base = start_cnt;
		for (i = 0; i < 8; i++) begin
			rnd = $random(seed);
			ws = rnd[3:0];
			if (ws == cmd_start_strb) ws = 4'hF;
			wd = $random(seed);
			wd[3:2] = 2'b00;
			bus_write(32'h0C, wd, ws);
		end
		repeat (4) @(negedge S_AXI_ACLK);
		check("cmd_start_other_strb", 32'(start_cnt - base), 32'd0);
		crst_base = crst_cnt;
		drst_base = drst_cnt;
		bus_write(32'h30, 32'h0, 4'hF);
		repeat (4) @(negedge S_AXI_ACLK);
		check("cmd_int_rst_count", 32'(crst_cnt - crst_base), 32'd1);
		check("dat_int_rst_count", 32'(drst_cnt - drst_base), 32'd1);

		// Interrupt status from held sources with a clear mask
		bus_write(32'h34, 32'h1FFFFFFF, 4'hF);
		for (i = 0; i < 12; i++) begin
			rnd = $random(seed);
			c_src = rnd[4:0];
			d_src = rnd[9:5];
			if (c_src == 5'd0 && d_src == 5'd0) d_src = 5'd1;
			cmd_int_st = c_src;
			dat_int_st = d_src;
			repeat (3) @(negedge S_AXI_ACLK);
			src = source_bits(c_src, d_src);
			check("int_status", 32'(int_status), 32'(src));
			read_check("int_status_read", 32'h30, {3'b0, src & m_int_en});
			wd = $random(seed);
			mask = wd[28:0];
			bus_write(32'h30, wd, 4'hF);
			read_check("int_status_masked", 32'h30, {3'b0, src & ~mask & m_int_en});
			check("int_status_out_masked", 32'(int_status), 32'(src & ~mask));
			// Mask forgotten once every source is idle
			cmd_int_st = '0;
			dat_int_st = '0;
			repeat (3) @(negedge S_AXI_ACLK);
			cmd_int_st = c_src;
			dat_int_st = d_src;
			repeat (3) @(negedge S_AXI_ACLK);
			read_check("int_status_unmasked", 32'h30, {3'b0, src & m_int_en});
			cmd_int_st = '0;
			dat_int_st = '0;
			repeat (3) @(negedge S_AXI_ACLK);
		end

		// Auto CMD23 with a good response
		bus_write(32'h00, $random(seed), 4'hF);
		bus_write(32'h08, $random(seed), 4'hF);
		bus_write(32'h0C, 32'h00000008, 4'h1);
		repeat (3) @(negedge S_AXI_ACLK);
		check("command_reg_cmd23", 32'(command_reg), 32'h171A);
		check("argument_reg_arg2", argument_reg, m_arg2);
		base = start_cnt;
		bus_write(32'h0C, {2'b00, 14'h0C52, 16'h0008}, 4'hC);
		wait_starts(base + 1);
		// Engine status of CMD23 is hidden and answered with a reset
		crst_base = crst_cnt;
		cmd_int_st = 5'h01;
		repeat (3) @(negedge S_AXI_ACLK);
		check("int_status_cmd23_cc", 32'(int_status), 32'h0);
		cmd_int_st = '0;
		repeat (2) @(negedge S_AXI_ACLK);
		check("cmd_int_rst_cmd23", 32'(crst_cnt > crst_base), 32'd1);
		rnd = $random(seed);
		response_0 = {rnd[31:16], 16'h0900};
		pulse_cc();
		wait_starts(base + 2);
		repeat (3) @(negedge S_AXI_ACLK);
		check("cmd_start_second", 32'(start_cnt - base), 32'd2);
		check("command_reg_real", 32'(command_reg), 32'(m_cmd[29:16]));
		check("argument_reg_arg1", argument_reg, m_arg1);
		// Completion of the real command
		pulse_cc();
		repeat (3) @(negedge S_AXI_ACLK);

		// Auto CMD23 with a bad response
		base = start_cnt;
		bus_write(32'h0C, {2'b00, 14'h0C52, 16'h0008}, 4'hC);
		wait_starts(base + 1);
		rnd = $random(seed);
		if (rnd[15:0] == 16'h0900) rnd[0] = 1'b1;
		response_0 = rnd;
		pulse_cc();
		repeat (8) @(negedge S_AXI_ACLK);
		check("cmd_start_no_second", 32'(start_cnt - base), 32'd1);
		read_check("acmd_err_set", 32'h30, 32'h01000000 & {3'b0, m_int_en});
		bus_write(32'h30, 32'h0, 4'hF);
		repeat (2) @(negedge S_AXI_ACLK);
		read_check("acmd_err_clear", 32'h30, 32'h0);
		bus_write(32'h0C, 32'h0, 4'h1);
		repeat (3) @(negedge S_AXI_ACLK);

		$display("Errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule
